// File: logic/ahb_mem_pkg.sv
`default_nettype none

package ahb_mem_pkg;

    // --------------------
    // address map.
    localparam int unsigned REG_SPACE_BIT = 12;

    // register word offsets inside register space.
    localparam int unsigned REG_CTRL_OFS    = 0;
    localparam int unsigned REG_WRCNT_OFS   = 1;
    localparam int unsigned REG_SCRATCH_OFS = 2;

    // --------------------
    // control word, seen as raw bus data or as steering fields.
    typedef struct packed {
        logic [26:0] reserved;
        logic        write_protect;
        logic [3:0]  wait_cycles;
    } ctrl_fields_t;

    typedef union packed {
        logic [31:0]  raw;
        ctrl_fields_t fields;
    } ctrl_word_u;

endpackage

`default_nettype wire

// File: logic/ahb_slave.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_slave #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 32
) (
    input  wire                   i_clk_ahb,
    input  wire                   i_rstn_ahb,

    input  wire                   i_hready,
    input  wire                   i_htrans,
    input  wire  [2:0]            i_hsize,
    input  wire                   i_hwrite,
    input  wire  [ADDR_WIDTH-1:0] i_haddr,
    input  wire  [DATA_WIDTH-1:0] i_hwdata,
    input  wire                   i_hselx,

    input  wire                   i_ready,
    input  wire                   i_rd_valid,
    input  wire  [DATA_WIDTH-1:0] i_rd_data,

    output logic                  o_hreadyout,
    output logic                  o_hresp,
    output logic [DATA_WIDTH-1:0] o_hrdata,

    output logic                  o_valid,
    output logic                  o_rd0_wr1,
    output logic [DATA_WIDTH-1:0] o_wr_data,
    output logic [ADDR_WIDTH-1:0] o_addr
);

    typedef enum logic {
        IDLE   = 1'b0,
        NONSEQ = 1'b1
    } state_t;

    state_t                state_q;
    logic                  write_q;
    logic                  rd_sent_q;
    logic [ADDR_WIDTH-1:0] addr_q;

    logic accept;
    logic dp_done;
    logic dp_wr_strobe;
    logic dp_rd_strobe;
    logic dp_rd_done;
    logic ap_rd_strobe;

    // --------------------
    // data phase of the transfer held in addr_q/write_q.
    always_comb begin
        dp_done      = 1'b1;
        dp_wr_strobe = 1'b0;
        dp_rd_strobe = 1'b0;
        dp_rd_done   = 1'b0;
        if (state_q == NONSEQ) begin
            if (write_q) begin
                dp_wr_strobe = i_ready;
                dp_done      = i_ready;
            end else if (!rd_sent_q) begin
                // read was held back in its address phase.
                dp_rd_strobe = i_ready;
                dp_done      = 1'b0;
            end else begin
                dp_rd_done = i_rd_valid;
                dp_done    = i_rd_valid;
            end
        end
    end

    // --------------------
    // address phase; a read goes out at once when the slot is free.
    assign accept       = i_hselx && i_htrans && i_hready && dp_done;
    assign ap_rd_strobe = accept && !i_hwrite && i_ready && !dp_wr_strobe;

    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            state_q   <= IDLE;
            write_q   <= 1'b0;
            rd_sent_q <= 1'b0;
        end else begin
            if (accept) begin
                state_q   <= NONSEQ;
                write_q   <= i_hwrite;
                rd_sent_q <= ap_rd_strobe;
            end else if (dp_done) begin
                state_q <= IDLE;
            end else if (dp_rd_strobe) begin
                rd_sent_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk_ahb) begin
        if (accept) begin
            addr_q <= i_haddr;
        end
    end

    // request bus.
    assign o_valid   = dp_wr_strobe || dp_rd_strobe || ap_rd_strobe;
    assign o_rd0_wr1 = dp_wr_strobe;
    assign o_addr    = ap_rd_strobe ? i_haddr : addr_q;
    assign o_wr_data = dp_wr_strobe ? i_hwdata : '0;

    // bus response.
    assign o_hreadyout = dp_done;
    assign o_hresp     = 1'b0;
    assign o_hrdata    = dp_rd_done ? i_rd_data : '0;

    // --------------------
    okay_only: assert property (@(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        !o_hresp)
        else $error("ahb_slave: error response driven");

    strobe_needs_ready: assert property (@(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        o_valid |-> i_ready)
        else $error("ahb_slave: strobe while target not ready");

    // only word transfers are handled by this port.
    word_size_only: assert property (@(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        accept |-> (i_hsize == 3'b010))
        else $error("ahb_slave: transfer size is not a word");

endmodule

`default_nettype wire

// File: logic/req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module req_decode
    import ahb_mem_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 32
) (
    input  wire                   i_valid,
    input  wire  [ADDR_WIDTH-1:0] i_addr,
    output logic                  o_ready,
    output logic                  o_rd_valid,
    output logic [DATA_WIDTH-1:0] o_rd_data,

    output logic                  o_mem_valid,
    input  wire                   i_mem_ready,
    input  wire                   i_mem_rd_valid,
    input  wire  [DATA_WIDTH-1:0] i_mem_rd_data,

    output logic                  o_reg_valid,
    input  wire                   i_reg_rd_valid,
    input  wire  [DATA_WIDTH-1:0] i_reg_rd_data
);

    logic sel_reg;

    assign sel_reg = i_addr[REG_SPACE_BIT];

    // strobe routing.
    assign o_mem_valid = i_valid && !sel_reg;
    assign o_reg_valid = i_valid && sel_reg;

    // registers never stall, so only the memory can hold the bus.
    assign o_ready = i_mem_ready;

    // read return merge.
    assign o_rd_valid = i_mem_rd_valid || i_reg_rd_valid;
    assign o_rd_data  = i_reg_rd_valid ? i_reg_rd_data : i_mem_rd_data;

    // one read in flight at a time across both targets.
    rd_return_onehot: assert final (!(i_mem_rd_valid && i_reg_rd_valid))
        else $error("req_decode: memory and register returns collide");

endmodule

`default_nettype wire

// File: logic/wait_mem.sv
`timescale 1ns/1ps
`default_nettype none

module wait_mem #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 32,
    parameter int MEM_WORDS  = 256
) (
    input  wire                   i_clk_ahb,
    input  wire                   i_rstn_ahb,

    input  wire                   i_valid,
    input  wire                   i_rd0_wr1,
    input  wire  [ADDR_WIDTH-1:0] i_addr,
    input  wire  [DATA_WIDTH-1:0] i_wr_data,

    input  wire  [3:0]            i_wait_cycles,
    input  wire                   i_write_protect,

    output logic                  o_ready,
    output logic                  o_rd_valid,
    output logic [DATA_WIDTH-1:0] o_rd_data,
    output logic                  o_wr_done
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    logic [3:0]       wait_cnt_q;
    logic             rd_pend_q;
    logic [IDX_W-1:0] rd_idx_q;
    logic [IDX_W-1:0] req_idx;
    logic             wr_fire;

    // word index sits above the byte offset.
    assign req_idx = i_addr[IDX_W+1:2];
    assign wr_fire = i_valid && i_rd0_wr1 && !i_write_protect;

    assign o_ready    = (wait_cnt_q == 4'd0);
    assign o_rd_valid = rd_pend_q && (wait_cnt_q == 4'd0);
    assign o_rd_data  = mem[rd_idx_q];

    // --------------------
    // wait-state counter.
    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            wait_cnt_q <= 4'd0;
            rd_pend_q  <= 1'b0;
            o_wr_done  <= 1'b0;
        end else begin
            o_wr_done <= wr_fire;
            if (i_valid) begin
                wait_cnt_q <= i_wait_cycles;
                rd_pend_q  <= !i_rd0_wr1;
            end else begin
                if (wait_cnt_q != 4'd0) begin
                    wait_cnt_q <= wait_cnt_q - 4'd1;
                end
                if (o_rd_valid) begin
                    rd_pend_q <= 1'b0;
                end
            end
        end
    end

    // storage; protected writes are dropped.
    always_ff @(posedge i_clk_ahb) begin
        if (wr_fire) begin
            mem[req_idx] <= i_wr_data;
        end
        if (i_valid && !i_rd0_wr1) begin
            rd_idx_q <= req_idx;
        end
    end

    no_strobe_when_busy: assert property (@(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        i_valid |-> o_ready)
        else $error("wait_mem: strobe during wait states");

endmodule

`default_nettype wire

// File: logic/mem_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_regs
    import ahb_mem_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  wire                      i_clk_ahb,
    input  wire                      i_rstn_ahb,

    input  wire                      i_valid,
    input  wire                      i_rd0_wr1,
    input  wire  [REG_SPACE_BIT-1:0] i_addr,
    input  wire  [DATA_WIDTH-1:0]    i_wr_data,
    input  wire                      i_wr_done,

    output logic                     o_rd_valid,
    output logic [DATA_WIDTH-1:0]    o_rd_data,

    output logic [3:0]               o_wait_cycles,
    output logic                     o_write_protect
);

    ctrl_word_u            ctrl_q;
    logic [DATA_WIDTH-1:0] wrcnt_q;
    logic [DATA_WIDTH-1:0] scratch_q;

    logic [REG_SPACE_BIT-3:0] word_ofs;
    logic                     wr_en;
    logic [DATA_WIDTH-1:0]    rd_mux;

    assign word_ofs = i_addr[REG_SPACE_BIT-1:2];
    assign wr_en    = i_valid && i_rd0_wr1;

    // --------------------
    // register file.
    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            ctrl_q     <= '0;
            wrcnt_q    <= '0;
            scratch_q  <= '0;
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= i_valid && !i_rd0_wr1;
            if (wr_en && (word_ofs == REG_CTRL_OFS)) begin
                ctrl_q.raw <= i_wr_data;
            end
            if (wr_en && (word_ofs == REG_SCRATCH_OFS)) begin
                scratch_q <= i_wr_data;
            end
            // WRCNT counts landed memory writes only.
            if (i_wr_done) begin
                wrcnt_q <= wrcnt_q + 1'b1;
            end
        end
    end

    // --------------------
    // read path.
    always_comb begin
        if (word_ofs == REG_CTRL_OFS) begin
            rd_mux = ctrl_q.raw;
        end else if (word_ofs == REG_WRCNT_OFS) begin
            rd_mux = wrcnt_q;
        end else if (word_ofs == REG_SCRATCH_OFS) begin
            rd_mux = scratch_q;
        end else begin
            rd_mux = '0;
        end
    end

    always_ff @(posedge i_clk_ahb) begin
        if (i_valid && !i_rd0_wr1) begin
            o_rd_data <= rd_mux;
        end
    end

    // memory steering from the field view.
    assign o_wait_cycles   = ctrl_q.fields.wait_cycles;
    assign o_write_protect = ctrl_q.fields.write_protect;

endmodule

`default_nettype wire

// File: logic/ahb_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_mem_top
    import ahb_mem_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 32,
    parameter int MEM_WORDS  = 256
) (
    input  wire                   i_clk_ahb,
    input  wire                   i_rstn_ahb,
    input  wire                   i_hready,
    input  wire                   i_htrans,
    input  wire  [2:0]            i_hsize,
    input  wire                   i_hwrite,
    input  wire  [ADDR_WIDTH-1:0] i_haddr,
    input  wire  [DATA_WIDTH-1:0] i_hwdata,
    input  wire                   i_hselx,
    output logic                  o_hreadyout,
    output logic                  o_hresp,
    output logic [DATA_WIDTH-1:0] o_hrdata
);

    // --------------------
    // request bus.
    logic                  req_valid;
    logic                  req_rd0_wr1;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic [DATA_WIDTH-1:0] req_wr_data;
    logic                  req_ready;
    logic                  req_rd_valid;
    logic [DATA_WIDTH-1:0] req_rd_data;

    // target ports.
    logic                  mem_valid;
    logic                  mem_ready;
    logic                  mem_rd_valid;
    logic [DATA_WIDTH-1:0] mem_rd_data;
    logic                  mem_wr_done;
    logic                  reg_valid;
    logic                  reg_rd_valid;
    logic [DATA_WIDTH-1:0] reg_rd_data;

    // steering.
    logic [3:0]            cfg_wait_cycles;
    logic                  cfg_write_protect;

    ahb_slave #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ahb_slave (
        .i_clk_ahb   (i_clk_ahb),
        .i_rstn_ahb  (i_rstn_ahb),
        .i_hready    (i_hready),
        .i_htrans    (i_htrans),
        .i_hsize     (i_hsize),
        .i_hwrite    (i_hwrite),
        .i_haddr     (i_haddr),
        .i_hwdata    (i_hwdata),
        .i_hselx     (i_hselx),
        .i_ready     (req_ready),
        .i_rd_valid  (req_rd_valid),
        .i_rd_data   (req_rd_data),
        .o_hreadyout (o_hreadyout),
        .o_hresp     (o_hresp),
        .o_hrdata    (o_hrdata),
        .o_valid     (req_valid),
        .o_rd0_wr1   (req_rd0_wr1),
        .o_wr_data   (req_wr_data),
        .o_addr      (req_addr)
    );

    req_decode #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_req_decode (
        .i_valid        (req_valid),
        .i_addr         (req_addr),
        .o_ready        (req_ready),
        .o_rd_valid     (req_rd_valid),
        .o_rd_data      (req_rd_data),
        .o_mem_valid    (mem_valid),
        .i_mem_ready    (mem_ready),
        .i_mem_rd_valid (mem_rd_valid),
        .i_mem_rd_data  (mem_rd_data),
        .o_reg_valid    (reg_valid),
        .i_reg_rd_valid (reg_rd_valid),
        .i_reg_rd_data  (reg_rd_data)
    );

    wait_mem #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .MEM_WORDS  (MEM_WORDS)
    ) u_wait_mem (
        .i_clk_ahb       (i_clk_ahb),
        .i_rstn_ahb      (i_rstn_ahb),
        .i_valid         (mem_valid),
        .i_rd0_wr1       (req_rd0_wr1),
        .i_addr          (req_addr),
        .i_wr_data       (req_wr_data),
        .i_wait_cycles   (cfg_wait_cycles),
        .i_write_protect (cfg_write_protect),
        .o_ready         (mem_ready),
        .o_rd_valid      (mem_rd_valid),
        .o_rd_data       (mem_rd_data),
        .o_wr_done       (mem_wr_done)
    );

    mem_ctrl_regs #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_mem_ctrl_regs (
        .i_clk_ahb       (i_clk_ahb),
        .i_rstn_ahb      (i_rstn_ahb),
        .i_valid         (reg_valid),
        .i_rd0_wr1       (req_rd0_wr1),
        .i_addr          (req_addr[REG_SPACE_BIT-1:0]),
        .i_wr_data       (req_wr_data),
        .i_wr_done       (mem_wr_done),
        .o_rd_valid      (reg_rd_valid),
        .o_rd_data       (reg_rd_data),
        .o_wait_cycles   (cfg_wait_cycles),
        .o_write_protect (cfg_write_protect)
    );

endmodule

`default_nettype wire

// File: testbench/tb_ahb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_mem
    import ahb_mem_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 64;

    logic        i_clk_ahb;
    logic        i_rstn_ahb;
    logic        i_hready;
    logic        i_htrans;
    logic [2:0]  i_hsize;
    logic        i_hwrite;
    logic [31:0] i_haddr;
    logic [31:0] i_hwdata;
    logic        i_hselx;
    logic        o_hreadyout;
    logic        o_hresp;
    logic [31:0] o_hrdata;

    integer seed = 17672;

    // reference model.
    logic [31:0] model_mem [256];
    logic [31:0] model_ctrl;
    logic [31:0] model_wrcnt;
    logic [31:0] model_scratch;

    ahb_mem_top #(
        .DATA_WIDTH (32),
        .ADDR_WIDTH (32),
        .MEM_WORDS  (256)
    ) dut (
        .i_clk_ahb   (i_clk_ahb),
        .i_rstn_ahb  (i_rstn_ahb),
        .i_hready    (i_hready),
        .i_htrans    (i_htrans),
        .i_hsize     (i_hsize),
        .i_hwrite    (i_hwrite),
        .i_haddr     (i_haddr),
        .i_hwdata    (i_hwdata),
        .i_hselx     (i_hselx),
        .o_hreadyout (o_hreadyout),
        .o_hresp     (o_hresp),
        .o_hrdata    (o_hrdata)
    );

    always #4 i_clk_ahb = ~i_clk_ahb;

    // --------------------
    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] mem_addr(input int idx);
        return 32'(idx) << 2;
    endfunction

    function automatic logic [31:0] reg_addr(input int ofs);
        return (32'd1 << REG_SPACE_BIT) | (32'(ofs) << 2);
    endfunction

    function automatic logic [31:0] expect_reg(input int ofs);
        if (ofs == REG_CTRL_OFS) begin
            return model_ctrl;
        end else if (ofs == REG_WRCNT_OFS) begin
            return model_wrcnt;
        end else if (ofs == REG_SCRATCH_OFS) begin
            return model_scratch;
        end
        return 32'h0;
    endfunction

    // --------------------
    // one single transfer; starts and ends 1 ns after a rising edge.
    task automatic ahb_xfer(input string name, input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int low_cycles);
        logic done;
        i_hselx  = 1'b1;
        i_htrans = 1'b1;
        i_hwrite = wr;
        i_haddr  = addr;
        @(posedge i_clk_ahb);
        #1;
        i_hselx    = 1'b0;
        i_htrans   = 1'b0;
        i_hwdata   = wr ? wdata : 32'h0;
        done       = 1'b0;
        low_cycles = 0;
        rdata      = 32'h0;
        while (!done && low_cycles < TIMEOUT_CYCLES) begin
            @(negedge i_clk_ahb);
            if (o_hreadyout) begin
                done  = 1'b1;
                rdata = o_hrdata;
                check_value({name, " hresp"}, 32'h0, 32'(o_hresp));
            end else begin
                low_cycles++;
            end
            @(posedge i_clk_ahb);
            #1;
        end
        if (!done) begin
            $display("timeout in %s, o_hreadyout stayed low for %0d cycles",
                     name, TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "transfer did not complete");
        end
    endtask

    // cycles without a valid transfer.
    task automatic idle_cycles(input string name, input int n, input logic sel,
                               input logic trans);
        repeat (n) begin
            i_hselx  = sel;
            i_htrans = trans;
            i_hwrite = 1'b1;
            // register space hits land on a mapped register.
            i_haddr  = $random(seed) & 32'h0000_1ffc;
            if (i_haddr[REG_SPACE_BIT]) begin
                i_haddr = reg_addr($unsigned($random(seed)) % 3);
            end
            i_hwdata = $random(seed);
            @(negedge i_clk_ahb);
            check_value(name, 32'h1, 32'(o_hreadyout));
            @(posedge i_clk_ahb);
            #1;
        end
        i_hselx  = 1'b0;
        i_htrans = 1'b0;
        i_hwrite = 1'b0;
    endtask

    task automatic mem_write(input int idx, input logic [31:0] data);
        logic [31:0] rdata;
        int          low;
        ahb_xfer("mem_write", 1'b1, mem_addr(idx), data, rdata, low);
        if (!model_ctrl[4]) begin
            model_mem[idx] = data;
            model_wrcnt++;
        end
    endtask

    task automatic mem_read_check(input string name, input int idx);
        logic [31:0] rdata;
        int          low;
        int          min_wait;
        min_wait = model_ctrl[3:0];
        ahb_xfer(name, 1'b0, mem_addr(idx), 32'h0, rdata, low);
        check_value(name, model_mem[idx], rdata);
        assert (low >= min_wait)
        else begin
            $display("[ERROR] %s: expected at least %0d wait cycles, actual %0d",
                     name, min_wait, low);
            $display("Simulation failed");
            $fatal(1, "too few wait cycles");
        end
    endtask

    task automatic reg_write(input int ofs, input logic [31:0] data);
        logic [31:0] rdata;
        int          low;
        ahb_xfer("reg_write", 1'b1, reg_addr(ofs), data, rdata, low);
        if (ofs == REG_CTRL_OFS) begin
            model_ctrl = data;
        end else if (ofs == REG_SCRATCH_OFS) begin
            model_scratch = data;
        end
    endtask

    task automatic reg_read_check(input string name, input int ofs);
        logic [31:0] rdata;
        int          low;
        // the write counter lags a landed memory write by two cycles.
        idle_cycles("settle", 2, 1'b0, 1'b0);
        ahb_xfer(name, 1'b0, reg_addr(ofs), 32'h0, rdata, low);
        check_value(name, expect_reg(ofs), rdata);
    endtask

    // --------------------
    initial begin
        int idx;
        i_clk_ahb     = 1'b0;
        i_rstn_ahb    = 1'b0;
        i_hready      = 1'b1;
        i_htrans      = 1'b0;
        i_hsize       = 3'b010;
        i_hwrite      = 1'b0;
        i_haddr       = 32'h0;
        i_hwdata      = 32'h0;
        i_hselx       = 1'b0;
        model_ctrl    = 32'h0;
        model_wrcnt   = 32'h0;
        model_scratch = 32'h0;
        repeat (3) @(posedge i_clk_ahb);
        #1;
        i_rstn_ahb = 1'b1;
        @(posedge i_clk_ahb);
        #1;

        // memory with zero wait cycles.
        for (int i = 0; i < 256; i++) begin
            mem_write(i, $random(seed));
        end
        repeat (300) begin
            idx = $random(seed) & 255;
            if ($random(seed) & 1) begin
                mem_write(idx, $random(seed));
            end else begin
                mem_read_check("mem_rw", idx);
            end
        end

        // programmed wait cycles.
        repeat (30) begin
            reg_write(REG_CTRL_OFS, $random(seed) & 15);
            repeat (8) begin
                idx = $random(seed) & 255;
                if ($random(seed) & 1) begin
                    mem_write(idx, $random(seed));
                end
                mem_read_check("mem_wait", idx);
            end
        end

        // write protect on, then off again.
        reg_write(REG_CTRL_OFS, 32'h10 | ($random(seed) & 3));
        repeat (16) begin
            idx = $random(seed) & 255;
            mem_write(idx, $random(seed));
            mem_read_check("wp_on", idx);
        end
        reg_write(REG_CTRL_OFS, 32'h0);
        repeat (16) begin
            idx = $random(seed) & 255;
            mem_write(idx, $random(seed));
            mem_read_check("wp_off", idx);
        end

        // write counter is read only.
        reg_read_check("wrcnt", REG_WRCNT_OFS);
        reg_write(REG_WRCNT_OFS, $random(seed));
        reg_read_check("wrcnt_ro", REG_WRCNT_OFS);

        // register readback and unmapped offsets.
        repeat (10) begin
            reg_write(REG_CTRL_OFS, $random(seed));
            reg_read_check("ctrl", REG_CTRL_OFS);
            reg_write(REG_SCRATCH_OFS, $random(seed));
            reg_read_check("scratch", REG_SCRATCH_OFS);
            reg_read_check("unmapped", 3 + ($unsigned($random(seed)) % 1021));
        end
        reg_write(REG_CTRL_OFS, 32'h0);

        // deselected and idle cycles change nothing.
        idle_cycles("hselx_low", 20, 1'b0, 1'b1);
        idle_cycles("htrans_idle", 20, 1'b1, 1'b0);
        reg_read_check("idle_ctrl", REG_CTRL_OFS);
        reg_read_check("idle_wrcnt", REG_WRCNT_OFS);
        reg_read_check("idle_scratch", REG_SCRATCH_OFS);
        for (int i = 0; i < 256; i++) begin
            mem_read_check("idle_mem", i);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
logic/ahb_mem_pkg.sv
logic/ahb_slave.sv
logic/req_decode.sv
logic/wait_mem.sv
logic/mem_ctrl_regs.sv
logic/ahb_mem_top.sv
testbench/tb_ahb_mem.sv

// File: Bender.yml
package:
  name: ahb_mem

sources:
  - files:
      - logic/ahb_mem_pkg.sv
      - logic/ahb_slave.sv
      - logic/req_decode.sv
      - logic/wait_mem.sv
      - logic/mem_ctrl_regs.sv
      - logic/ahb_mem_top.sv
  - target: test
    files:
      - testbench/tb_ahb_mem.sv
